//--- flist.f
+incdir+include
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/csr_access_if.sv
hw/csr_access_unit.sv
hw/csr_trap_regs.sv
hw/csr_counters.sv
hw/csr_regs_top.sv
verif/csr_regs_chk.sv
verif/csr_regs_tb.sv

//--- hw/csr_access_if.sv
// CSR register bank access bus

`timescale 1ns/1ps

interface csr_access_if;
    import csr_pkg::*;

    // Write side, driven by the access unit
    logic wr_en;
    csr_sel_t wr_sel;
    xlen_t wr_data;

    // Read side, bank answers combinationally
    csr_sel_t rd_sel;
    xlen_t rd_data;

    modport access (
        output wr_en, wr_sel, wr_data, rd_sel,
        input rd_data
    );

    modport bank (
        input wr_en, wr_sel, wr_data, rd_sel,
        output rd_data
    );

endinterface

//--- hw/csr_access_unit.sv
// CSR access decode and update

`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_access_unit (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic commit,
    input csr_pkg::csr_addr_t csr_addr,
    input csr_pkg::csr_op_t csr_op,
    input csr_pkg::xlen_t rs1,
    input trap_pkg::priv_t priv,
    output logic illegal_csr,
    output csr_pkg::xlen_t wb_csr,
    csr_access_if.access trap_bus,
    csr_access_if.access count_bus
);
    import csr_pkg::*;
    import trap_pkg::*;

    // RV32 with I, M, A and U
    localparam xlen_t MISA_VAL = 32'h4010_1101;

    csr_sel_t sel;
    logic addr_valid;
    logic priv_fault;
    logic read_only;
    logic trap_owned;
    logic count_owned;
    logic write_ok;
    logic illegal_r;
    xlen_t rd_mux;
    xlen_t rd_data_r;
    xlen_t new_val;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    always_comb begin
        addr_valid = 1'b1;
        case (csr_addr)
            CSR_MISA:      sel = SEL_MISA;
            CSR_MVENDORID: sel = SEL_MVENDORID;
            CSR_MARCHID:   sel = SEL_MARCHID;
            CSR_MIMPID:    sel = SEL_MIMPID;
            CSR_MHARTID:   sel = SEL_MHARTID;
            CSR_MSTATUS:   sel = SEL_MSTATUS;
            CSR_MIE:       sel = SEL_MIE;
            CSR_MTVEC:     sel = SEL_MTVEC;
            CSR_MSCRATCH:  sel = SEL_MSCRATCH;
            CSR_MEPC:      sel = SEL_MEPC;
            CSR_MCAUSE:    sel = SEL_MCAUSE;
            CSR_MTVAL:     sel = SEL_MTVAL;
            CSR_MIP:       sel = SEL_MIP;
            CSR_MCYCLE:    sel = SEL_MCYCLE;
            CSR_MCYCLEH:   sel = SEL_MCYCLEH;
            CSR_MINSTRET:  sel = SEL_MINSTRET;
            CSR_MINSTRETH: sel = SEL_MINSTRETH;
            CSR_CYCLE:     sel = SEL_CYCLE;
            CSR_CYCLEH:    sel = SEL_CYCLEH;
            CSR_TIME:      sel = SEL_TIME;
            CSR_TIMEH:     sel = SEL_TIMEH;
            CSR_INSTRET:   sel = SEL_INSTRET;
            CSR_INSTRETH:  sel = SEL_INSTRETH;
            default: begin
                sel = SEL_NONE;
                addr_valid = 1'b0;
            end
        endcase
    end

    assign trap_owned = sel inside {SEL_MSTATUS, SEL_MIE, SEL_MTVEC, SEL_MSCRATCH,
                                    SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP};
    assign count_owned = sel inside {SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
                                     SEL_CYCLE, SEL_CYCLEH, SEL_TIME, SEL_TIMEH,
                                     SEL_INSTRET, SEL_INSTRETH};

    // Privilege field sits in [9:8]
    assign priv_fault = csr_addr[9:8] > priv;
    assign read_only = csr_addr[11:10] == 2'b11;
    assign illegal_csr = new_request & (~addr_valid | priv_fault);

    ////////////////////////////////////////////////////////////////////////////
    // Read path
    assign trap_bus.rd_sel = sel;
    assign count_bus.rd_sel = sel;

    always_comb begin
        case (sel)
            SEL_MISA:      rd_mux = MISA_VAL;
            SEL_MVENDORID: rd_mux = '0;
            SEL_MARCHID:   rd_mux = '0;
            SEL_MIMPID:    rd_mux = '0;
            SEL_MHARTID:   rd_mux = xlen_t'(`CSR_CPU_ID);
            default: begin
                if (trap_owned)
                    rd_mux = trap_bus.rd_data;
                else if (count_owned)
                    rd_mux = count_bus.rd_data;
                else
                    rd_mux = '0;
            end
        endcase
    end

    // Read value and illegal flag held until the commit
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_r <= '0;
            illegal_r <= 1'b0;
        end else if (new_request) begin
            rd_data_r <= rd_mux;
            illegal_r <= ~addr_valid | priv_fault;
        end
    end

    assign wb_csr = rd_data_r;

    ////////////////////////////////////////////////////////////////////////////
    // Write path
    always_comb begin
        case (csr_op)
            CSR_RW:  new_val = rs1;
            CSR_RS:  new_val = rd_data_r | rs1;
            CSR_RC:  new_val = rd_data_r & ~rs1;
            default: new_val = rs1;
        endcase
    end

    // misa and the id block have no owner, so writes to them drop here
    assign write_ok = commit & ~illegal_r & ~read_only;

    assign trap_bus.wr_en = write_ok & trap_owned;
    assign trap_bus.wr_sel = sel;
    assign trap_bus.wr_data = new_val;

    assign count_bus.wr_en = write_ok & count_owned;
    assign count_bus.wr_sel = sel;
    assign count_bus.wr_data = new_val;

endmodule

//--- hw/csr_counters.sv
// Cycle and retired instruction counters

`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_counters (
    input logic clk,
    input logic rst,
    input logic instruction_complete,
    input logic instruction_issued_no_rd,
    csr_access_if.bank bus
);
    import csr_pkg::*;

    counter_t mcycle;
    counter_t minstret;
    logic [1:0] ret_inc;

    // Up to two retirements per cycle, added one cycle later
    always_ff @(posedge clk) begin
        if (rst)
            ret_inc <= 2'd0;
        else
            ret_inc <= {1'b0, instruction_complete} + {1'b0, instruction_issued_no_rd};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            minstret <= minstret + counter_t'(ret_inc);
        end
    end

    // time aliases mcycle
    always_comb begin
        case (bus.rd_sel)
            SEL_MCYCLE, SEL_CYCLE, SEL_TIME:       bus.rd_data = mcycle[`XLEN-1:0];
            SEL_MCYCLEH, SEL_CYCLEH, SEL_TIMEH:    bus.rd_data = mcycle[`COUNTER_W-1:`XLEN];
            SEL_MINSTRET, SEL_INSTRET:             bus.rd_data = minstret[`XLEN-1:0];
            SEL_MINSTRETH, SEL_INSTRETH:           bus.rd_data = minstret[`COUNTER_W-1:`XLEN];
            default:                               bus.rd_data = '0;
        endcase
    end

endmodule

//--- hw/csr_pkg.sv
// CSR access types and addresses

`include "csr_defines.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`COUNTER_W-1:0] counter_t;

    // [11:10] read-only marker when 11, [9:8] lowest privilege allowed
    typedef logic [11:0] csr_addr_t;

    // Low two bits of the funct3 field
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    // One code per implemented register
    typedef enum logic [4:0] {
        SEL_NONE, SEL_MISA, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID,
        SEL_MSTATUS, SEL_MIE, SEL_MTVEC, SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE,
        SEL_MTVAL, SEL_MIP, SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_CYCLE, SEL_CYCLEH, SEL_TIME, SEL_TIMEH, SEL_INSTRET, SEL_INSTRETH
    } csr_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Machine information and trap registers
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    ////////////////////////////////////////////////////////////////////////////
    // Counters and their user aliases
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_TIME      = 12'hC01;
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;
    localparam csr_addr_t CSR_TIMEH     = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH  = 12'hC82;

endpackage

//--- hw/csr_regs_top.sv
// Machine mode CSR unit

`timescale 1ns/1ps

module csr_regs_top (
    input logic clk,
    input logic rst,

    // Access
    input logic new_request,
    input logic commit,
    input csr_pkg::csr_addr_t csr_addr,
    input csr_pkg::csr_op_t csr_op,
    input csr_pkg::xlen_t rs1,

    // Trap control
    input logic exc_valid,
    input trap_pkg::ecode_t exc_code,
    input csr_pkg::xlen_t exc_pc,
    input csr_pkg::xlen_t exc_tval,
    input logic mret,

    // Retirement
    input logic instruction_complete,
    input logic instruction_issued_no_rd,

    output logic illegal_csr,
    output trap_pkg::priv_t current_privilege,
    output csr_pkg::xlen_t wb_csr,
    output csr_pkg::xlen_t trap_pc,
    output csr_pkg::xlen_t csr_mepc
);

    csr_access_if trap_bus ();
    csr_access_if count_bus ();

    csr_access_unit access0 (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .commit      (commit),
        .csr_addr    (csr_addr),
        .csr_op      (csr_op),
        .rs1         (rs1),
        .priv        (current_privilege),
        .illegal_csr (illegal_csr),
        .wb_csr      (wb_csr),
        .trap_bus    (trap_bus.access),
        .count_bus   (count_bus.access)
    );

    csr_trap_regs trap0 (
        .clk       (clk),
        .rst       (rst),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),
        .exc_pc    (exc_pc),
        .exc_tval  (exc_tval),
        .mret      (mret),
        .priv      (current_privilege),
        .trap_pc   (trap_pc),
        .csr_mepc  (csr_mepc),
        .bus       (trap_bus.bank)
    );

    csr_counters count0 (
        .clk                      (clk),
        .rst                      (rst),
        .instruction_complete     (instruction_complete),
        .instruction_issued_no_rd (instruction_issued_no_rd),
        .bus                      (count_bus.bank)
    );

endmodule

//--- hw/csr_trap_regs.sv
// Machine trap registers

`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_trap_regs (
    input logic clk,
    input logic rst,
    input logic exc_valid,
    input trap_pkg::ecode_t exc_code,
    input csr_pkg::xlen_t exc_pc,
    input csr_pkg::xlen_t exc_tval,
    input logic mret,
    output trap_pkg::priv_t priv,
    output csr_pkg::xlen_t trap_pc,
    output csr_pkg::xlen_t csr_mepc,
    csr_access_if.bank bus
);
    import csr_pkg::*;
    import trap_pkg::*;

    xlen_t mstatus;
    xlen_t mie_reg;
    xlen_t mip_reg;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mscratch;

    xlen_t mstatus_wval;
    xlen_t mstatus_trap;
    xlen_t mstatus_ret;

    ////////////////////////////////////////////////////////////////////////////
    // mstatus next values
    always_comb begin
        mstatus_wval = bus.wr_data & MSTATUS_WMASK;
        // mpp only holds user or machine
        if (bus.wr_data[MSTATUS_MPP_HI:MSTATUS_MPP_LO] != 2'b00)
            mstatus_wval[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = PRIV_MACHINE;
    end

    always_comb begin
        mstatus_trap = mstatus;
        mstatus_trap[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
        mstatus_trap[MSTATUS_MIE] = 1'b0;
        mstatus_trap[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = priv;
    end

    always_comb begin
        mstatus_ret = mstatus;
        mstatus_ret[MSTATUS_MIE] = mstatus[MSTATUS_MPIE];
        mstatus_ret[MSTATUS_MPIE] = 1'b1;
        mstatus_ret[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = PRIV_USER;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Privilege and mstatus
    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_MACHINE;
            mstatus <= `CSR_MSTATUS_RST;
        end else if (exc_valid) begin
            priv <= PRIV_MACHINE;
            mstatus <= mstatus_trap;
        end else if (mret) begin
            priv <= priv_t'(mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
            mstatus <= mstatus_ret;
        end else if (bus.wr_en && bus.wr_sel == SEL_MSTATUS) begin
            mstatus <= mstatus_wval;
        end
    end

    // Trap entry overrides software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
        end else if (exc_valid) begin
            mepc <= {exc_pc[`XLEN-1:2], 2'b00};
            mcause <= xlen_t'(exc_code);
            mtval <= exc_tval;
        end else if (bus.wr_en) begin
            if (bus.wr_sel == SEL_MEPC)
                mepc <= {bus.wr_data[`XLEN-1:2], 2'b00};
            if (bus.wr_sel == SEL_MCAUSE)
                mcause <= bus.wr_data & MCAUSE_WMASK;
            if (bus.wr_sel == SEL_MTVAL)
                mtval <= bus.wr_data;
        end
    end

    // Software-only registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_reg <= '0;
            mip_reg <= '0;
            mtvec <= `CSR_MTVEC_RST;
            mscratch <= '0;
        end else if (bus.wr_en) begin
            case (bus.wr_sel)
                SEL_MIE:      mie_reg <= bus.wr_data & MIE_WMASK;
                SEL_MIP:      mip_reg <= bus.wr_data & MIP_WMASK;
                SEL_MTVEC:    mtvec <= {bus.wr_data[`XLEN-1:2], 2'b00};
                SEL_MSCRATCH: mscratch <= bus.wr_data;
                default:      mscratch <= mscratch;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux
    always_comb begin
        case (bus.rd_sel)
            SEL_MSTATUS:  bus.rd_data = mstatus;
            SEL_MIE:      bus.rd_data = mie_reg;
            SEL_MIP:      bus.rd_data = mip_reg;
            SEL_MTVEC:    bus.rd_data = mtvec;
            SEL_MSCRATCH: bus.rd_data = mscratch;
            SEL_MEPC:     bus.rd_data = mepc;
            SEL_MCAUSE:   bus.rd_data = mcause;
            SEL_MTVAL:    bus.rd_data = mtval;
            default:      bus.rd_data = '0;
        endcase
    end

    // Direct mode only
    assign trap_pc = mtvec;
    assign csr_mepc = mepc;

endmodule

//--- hw/trap_pkg.sv
// Privilege and trap types

`include "csr_defines.svh"

package trap_pkg;

    // Only user and machine levels exist
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_t;

    typedef logic [`ECODE_W-1:0] ecode_t;

    ////////////////////////////////////////////////////////////////////////////
    // mstatus field positions
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;

    // mcause interrupt flag
    localparam int MCAUSE_INT = `XLEN-1;

    ////////////////////////////////////////////////////////////////////////////
    // Writable bits per register
    localparam logic [`XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;
    // msie, mtie, meie
    localparam logic [`XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
    // msip only
    localparam logic [`XLEN-1:0] MIP_WMASK     = 32'h0000_0008;
    localparam logic [`XLEN-1:0] MCAUSE_WMASK  = 32'h8000_001F;

endpackage

//--- include/csr_defines.svh
// CSR unit global definitions

`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Architectural widths
`define XLEN 32
`define COUNTER_W 64
`define ECODE_W 5

// Hart identity
`define CSR_CPU_ID 0

// Reset values
`define CSR_MTVEC_RST 32'h0000_0100
`define CSR_MSTATUS_RST 32'h0000_1800

`endif

//--- run.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module csr_regs_tb \
    -f flist.f -o csr_regs_sim || { echo "Build failed"; exit 1; }

./obj_dir/csr_regs_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- verif/csr_regs_chk.sv
// CSR unit port assertions

`timescale 1ns/1ps

module csr_regs_chk (
    input logic clk,
    input logic rst,
    input logic new_request,
    input logic illegal_csr,
    input logic exc_valid,
    input trap_pkg::priv_t current_privilege,
    input csr_pkg::xlen_t trap_pc,
    input csr_pkg::xlen_t csr_mepc
);
    import trap_pkg::*;

    // Flag only qualifies a live request
    illegal_needs_request: assert property (@(posedge clk) disable iff (rst)
        illegal_csr |-> new_request)
        else $error("illegal_csr high without new_request");

    trap_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        trap_pc[1:0] == 2'b00)
        else $error("trap_pc low bits are not zero");

    mepc_aligned: assert property (@(posedge clk) disable iff (rst)
        csr_mepc[1:0] == 2'b00)
        else $error("csr_mepc low bits are not zero");

    // Trap entry always lands in machine mode
    trap_enters_machine: assert property (@(posedge clk) disable iff (rst)
        exc_valid |=> current_privilege == PRIV_MACHINE)
        else $error("current_privilege not MACHINE after exc_valid");

endmodule

//--- verif/csr_regs_tb.sv
// CSR unit testbench

`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_regs_tb;
    import csr_pkg::*;
    import trap_pkg::*;

    // Accesses, pulses and idle gaps budgeted by the watchdog
    localparam int NUM_OPS = 200;

    localparam csr_addr_t RMW_ADDRS [4] = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MIE, CSR_MIP};
    localparam csr_addr_t ID_ADDRS [5] = '{CSR_MISA, CSR_MVENDORID, CSR_MARCHID,
                                           CSR_MIMPID, CSR_MHARTID};
    localparam csr_addr_t HIGH_ADDRS [5] = '{CSR_MCYCLEH, CSR_MINSTRETH, CSR_CYCLEH,
                                             CSR_TIMEH, CSR_INSTRETH};
    localparam csr_addr_t CYCLE_ADDRS [3] = '{CSR_MCYCLE, CSR_CYCLE, CSR_TIME};

    logic clk = 1'b0;
    logic rst;
    logic new_request;
    logic commit;
    csr_addr_t csr_addr;
    csr_op_t csr_op;
    xlen_t rs1;
    logic exc_valid;
    ecode_t exc_code;
    xlen_t exc_pc;
    xlen_t exc_tval;
    logic mret;
    logic instruction_complete;
    logic instruction_issued_no_rd;
    logic illegal_csr;
    priv_t current_privilege;
    xlen_t wb_csr;
    xlen_t trap_pc;
    xlen_t csr_mepc;

    integer seed = 32'h7ffef57e;
    int errors = 0;
    int checks = 0;

    // Reference state of the writable trap registers
    xlen_t model [csr_addr_t];
    priv_t r_priv;

    // Request in flight
    logic exp_cmp = 1'b0;
    logic exp_ill = 1'b0;
    xlen_t exp_rd = '0;
    xlen_t last_rd = '0;
    longint req_time = 0;

    csr_regs_top dut0 (.*);

    bind csr_regs_top csr_regs_chk chk0 (
        .clk               (clk),
        .rst               (rst),
        .new_request       (new_request),
        .illegal_csr       (illegal_csr),
        .exc_valid         (exc_valid),
        .current_privilege (current_privilege),
        .trap_pc           (trap_pc),
        .csr_mepc          (csr_mepc)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic known_addr(csr_addr_t a);
        return (a inside {CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
                          CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH,
                          CSR_CYCLE, CSR_CYCLEH, CSR_TIME, CSR_TIMEH,
                          CSR_INSTRET, CSR_INSTRETH}) || model.exists(a);
    endfunction

    // Address bits [9:8] give the lowest privilege allowed
    function automatic logic access_illegal(csr_addr_t a);
        return !known_addr(a) || (a[9:8] > 2'(r_priv));
    endfunction

    function automatic xlen_t expected_read(csr_addr_t a);
        if (model.exists(a))
            return model[a];
        // RV32 base with I, M, A and U
        if (a == CSR_MISA)
            return (32'h1 << 30) | (32'h1 << 20) | (32'h1 << 12) | (32'h1 << 8) | 32'h1;
        if (a == CSR_MHARTID)
            return xlen_t'(`CSR_CPU_ID);
        // Vendor ids, unknown addresses and counter high halves
        return '0;
    endfunction

    function automatic xlen_t write_mask(csr_addr_t a, xlen_t v);
        xlen_t m;
        m = v;
        case (a)
            CSR_MSTATUS: begin
                // mie, mpie and mpp
                m = v & 32'h0000_1888;
                if (v[12:11] != 2'b00)
                    m[12:11] = 2'b11;
            end
            CSR_MIE:             m = v & 32'h0000_0888;
            CSR_MIP:             m = v & 32'h0000_0008;
            CSR_MTVEC, CSR_MEPC: m = v & ~32'h3;
            CSR_MCAUSE:          m = v & 32'h8000_001F;
            default:             m = v;
        endcase
        return m;
    endfunction

    task automatic apply_commit(input csr_addr_t a, input csr_op_t op, input xlen_t v);
        xlen_t old;
        xlen_t nv;
        old = expected_read(a);
        case (op)
            CSR_RS:  nv = old | v;
            CSR_RC:  nv = old & ~v;
            default: nv = v;
        endcase
        if (model.exists(a))
            model[a] = write_mask(a, nv);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Request, then an optional commit one cycle later
    task automatic csr_access(input csr_addr_t a, input csr_op_t op, input xlen_t v,
                              input logic do_commit, input logic chk);
        @(negedge clk);
        new_request = 1'b1;
        csr_addr = a;
        csr_op = op;
        rs1 = v;
        exp_rd = expected_read(a);
        exp_ill = access_illegal(a);
        exp_cmp = chk;
        req_time = $time;
        @(negedge clk);
        new_request = 1'b0;
        if (do_commit) begin
            commit = 1'b1;
            if (!exp_ill)
                apply_commit(a, op, v);
        end
        @(negedge clk);
        commit = 1'b0;
    endtask

    task automatic raise_trap(input ecode_t code, input xlen_t pc, input xlen_t tval);
        xlen_t st;
        @(negedge clk);
        exc_valid = 1'b1;
        exc_code = code;
        exc_pc = pc;
        exc_tval = tval;
        st = model[CSR_MSTATUS];
        st[7] = st[3];
        st[3] = 1'b0;
        st[12:11] = r_priv;
        model[CSR_MSTATUS] = st;
        model[CSR_MEPC] = pc & ~32'h3;
        model[CSR_MCAUSE] = xlen_t'(code);
        model[CSR_MTVAL] = tval;
        r_priv = PRIV_MACHINE;
        @(negedge clk);
        exc_valid = 1'b0;
    endtask

    task automatic issue_mret();
        xlen_t st;
        @(negedge clk);
        mret = 1'b1;
        st = model[CSR_MSTATUS];
        r_priv = (st[12:11] == 2'b00) ? PRIV_USER : PRIV_MACHINE;
        st[3] = st[7];
        st[7] = 1'b1;
        st[12:11] = 2'b00;
        model[CSR_MSTATUS] = st;
        @(negedge clk);
        mret = 1'b0;
    endtask

    // Flag checked in the request cycle, read data one cycle later
    initial begin
        forever begin
            @(negedge clk);
            #2;
            if (new_request) begin
                check_value("illegal_csr", xlen_t'(illegal_csr), xlen_t'(exp_ill));
                @(posedge clk);
                #1;
                if (exp_cmp)
                    check_value("wb_csr", wb_csr, exp_rd);
                last_rd = wb_csr;
            end
        end
    end

    initial begin
        #(NUM_OPS * 10 * 10 + 1000);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        xlen_t v1;
        longint t1;
        int pick;
        int sum;
        logic ic;
        logic inr;
        csr_addr_t a;
        csr_op_t op;

        rst = 1'b1;
        new_request = 1'b0;
        commit = 1'b0;
        csr_addr = '0;
        csr_op = CSR_RW;
        rs1 = '0;
        exc_valid = 1'b0;
        exc_code = '0;
        exc_pc = '0;
        exc_tval = '0;
        mret = 1'b0;
        instruction_complete = 1'b0;
        instruction_issued_no_rd = 1'b0;

        model[CSR_MSTATUS] = `CSR_MSTATUS_RST;
        model[CSR_MIE] = '0;
        model[CSR_MIP] = '0;
        model[CSR_MTVEC] = `CSR_MTVEC_RST;
        model[CSR_MSCRATCH] = '0;
        model[CSR_MEPC] = '0;
        model[CSR_MCAUSE] = '0;
        model[CSR_MTVAL] = '0;
        r_priv = PRIV_MACHINE;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_value("wb_csr", wb_csr, '0);
        check_value("illegal_csr", xlen_t'(illegal_csr), '0);
        check_value("current_privilege", xlen_t'(current_privilege), xlen_t'(PRIV_MACHINE));

        // Random read-modify-write, each followed by a read-back
        repeat (40) begin
            pick = $unsigned($random(seed)) % 4;
            a = RMW_ADDRS[2'(pick)];
            pick = $unsigned($random(seed)) % 3;
            op = (pick == 0) ? CSR_RW : ((pick == 1) ? CSR_RS : CSR_RC);
            csr_access(a, op, $random(seed), 1'b1, 1'b1);
            csr_access(a, CSR_RS, '0, 1'b0, 1'b1);
            check_value("trap_pc", trap_pc, expected_read(CSR_MTVEC));
        end

        // Identification registers ignore writes
        for (int i = 0; i < 5; i++) begin
            csr_access(ID_ADDRS[i], CSR_RW, $random(seed), 1'b1, 1'b1);
            csr_access(ID_ADDRS[i], CSR_RS, '0, 1'b0, 1'b1);
        end

        // Unknown address, then drop to user mode
        csr_access(12'h7C5, CSR_RW, 32'hDEAD_BEEF, 1'b1, 1'b1);
        csr_access(CSR_MSCRATCH, CSR_RS, '0, 1'b0, 1'b1);
        csr_access(CSR_MSTATUS, CSR_RC, 32'h0000_1800, 1'b1, 1'b1);
        issue_mret();
        check_value("current_privilege", xlen_t'(current_privilege), xlen_t'(PRIV_USER));
        csr_access(CSR_MSCRATCH, CSR_RW, 32'h1234_5678, 1'b1, 1'b1);
        csr_access(CSR_MSCRATCH, CSR_RS, '0, 1'b0, 1'b1);
        csr_access(CSR_MCYCLE, CSR_RS, '0, 1'b0, 1'b0);

        // Trap entry, first one taken from user mode
        for (int i = 0; i < 4; i++) begin
            csr_access(CSR_MSTATUS, CSR_RW, $random(seed), 1'b1, 1'b1);
            raise_trap(ecode_t'($random(seed)), $random(seed), $random(seed));
            check_value("current_privilege", xlen_t'(current_privilege),
                        xlen_t'(PRIV_MACHINE));
            check_value("csr_mepc", csr_mepc, expected_read(CSR_MEPC));
            csr_access(CSR_MEPC, CSR_RS, '0, 1'b0, 1'b1);
            csr_access(CSR_MCAUSE, CSR_RS, '0, 1'b0, 1'b1);
            csr_access(CSR_MTVAL, CSR_RS, '0, 1'b0, 1'b1);
            csr_access(CSR_MSTATUS, CSR_RS, '0, 1'b0, 1'b1);
        end

        // mcycle against itself and its aliases over a random gap
        for (int i = 0; i < 3; i++) begin
            csr_access(CSR_MCYCLE, CSR_RS, '0, 1'b0, 1'b0);
            v1 = last_rd;
            t1 = req_time;
            repeat (3 + $unsigned($random(seed)) % 8) @(negedge clk);
            csr_access(CYCLE_ADDRS[i], CSR_RS, '0, 1'b0, 1'b0);
            check_value("mcycle delta", last_rd - v1, xlen_t'((req_time - t1) / 10));
        end

        // Retirement burst
        sum = 0;
        repeat (20) begin
            @(negedge clk);
            ic = 1'($random(seed));
            inr = 1'($random(seed));
            instruction_complete = ic;
            instruction_issued_no_rd = inr;
            sum += int'(ic) + int'(inr);
        end
        @(negedge clk);
        instruction_complete = 1'b0;
        instruction_issued_no_rd = 1'b0;
        @(negedge clk);
        csr_access(CSR_MINSTRET, CSR_RS, '0, 1'b0, 1'b0);
        check_value("minstret", last_rd, xlen_t'(sum));
        csr_access(CSR_INSTRET, CSR_RS, '0, 1'b0, 1'b0);
        check_value("instret", last_rd, xlen_t'(sum));

        for (int i = 0; i < 5; i++)
            csr_access(HIGH_ADDRS[i], CSR_RS, '0, 1'b0, 1'b1);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
